/* gf64_butterfly_top.f */
logic/gf64_pkg.sv
logic/gf64_delay_side.sv
logic/gf64_pmr_addsub.sv
logic/gf64_final_red.sv
logic/gf64_butterfly_top.sv
test/gf64_butterfly_checker.sv
test/tb_gf64_butterfly.sv

/* run.sh */
#!/bin/sh
# Build and run the GF64 butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_gf64_butterfly \
  -f gf64_butterfly_top.f

# Raise the error limit so assertion failures still reach the closing summary
out=$(./obj_dir/Vtb_gf64_butterfly +verilator+error+limit+1000 2>&1 || true)
echo "$out"

# The verdict comes from the testbench's own closing message
if echo "$out" | grep -q 'All tests passed!'; then
  exit 0
else
  exit 1
fi

/* test/tb_gf64_butterfly.sv */
// Testbench for the GF64 add/subtract butterfly top level
// Expected results come from a 128-bit signed model of (a +/- b) mod p
// Inputs change on the falling edge, outputs are read on the falling edge
module tb_gf64_butterfly;
  timeunit 1ns;
  timeprecision 1ps;
  import gf64_pkg::*;

  // DUT ports
  logic             clk;
  logic             rst_n;
  logic [OP_W-1:0]  a;
  logic [OP_W-1:0]  b;
  logic             in_avail;
  tag_t             in_tag;
  logic [MOD_W-1:0] sum;
  logic [MOD_W-1:0] diff;
  logic             out_avail;
  tag_t             out_tag;

  // Scoreboard, one entry per item in flight, oldest first
  logic [MOD_W-1:0] exp_sum_q [$];
  logic [MOD_W-1:0] exp_diff_q [$];
  tag_t             exp_tag_q [$];
  logic [MOD_W-1:0] want_sum;
  logic [MOD_W-1:0] want_diff;
  tag_t             want_tag;

  int               errors;
  int               tests;
  int               err_base;
  int               seed;
  int               lat;
  int               gap;
  int               total;
  logic [OP_W-1:0]  ra;
  logic [OP_W-1:0]  rb;
  tag_t             rt;

  gf64_butterfly_top i_gf64_butterfly_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (a),
    .b         (b),
    .in_avail  (in_avail),
    .in_tag    (in_tag),
    .sum       (sum),
    .diff      (diff),
    .out_avail (out_avail),
    .out_tag   (out_tag)
  );

  bind gf64_butterfly_top gf64_butterfly_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_avail  (in_avail),
    .in_tag    (in_tag),
    .out_avail (out_avail),
    .out_tag   (out_tag),
    .sum       (sum),
    .diff      (diff)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic signed [127:0] widen(input logic [OP_W-1:0] v);
    return {{(128-OP_W){v[OP_W-1]}}, v};
  endfunction

  // Non-negative remainder, % keeps the sign of the dividend
  function automatic logic [MOD_W-1:0] mod_p(input logic signed [127:0] v);
    logic signed [127:0] p_wide;
    logic signed [127:0] m;
    p_wide = {64'd0, GF64_P};
    m = v % p_wide;
    if (m[127]) begin
      m = m + p_wide;
    end
    return m[MOD_W-1:0];
  endfunction

  // Full 66-bit signed range
  function automatic logic [OP_W-1:0] rand_operand();
    int r0;
    int r1;
    int r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    return {r2[1:0], r1, r0};
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic drive_item(input logic [OP_W-1:0] va, input logic [OP_W-1:0] vb,
                            input tag_t vt);
    @(negedge clk);
    a = va;
    b = vb;
    in_tag = vt;
    in_avail = 1'b1;
  endtask

  // Expected values from the model
  task automatic send_item(input logic [OP_W-1:0] va, input logic [OP_W-1:0] vb,
                           input tag_t vt);
    drive_item(va, vb, vt);
    exp_sum_q.push_back(mod_p(widen(va) + widen(vb)));
    exp_diff_q.push_back(mod_p(widen(va) - widen(vb)));
    exp_tag_q.push_back(vt);
  endtask

  // Expected values given directly
  task automatic send_known(input logic [OP_W-1:0] va, input logic [OP_W-1:0] vb,
                            input tag_t vt, input logic [MOD_W-1:0] vs,
                            input logic [MOD_W-1:0] vd);
    drive_item(va, vb, vt);
    exp_sum_q.push_back(vs);
    exp_diff_q.push_back(vd);
    exp_tag_q.push_back(vt);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      in_avail = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input int base);
    $display("Test %0s finished, %0d errors", name, errors - base);
    tests++;
  endtask

  // Wait for the scoreboard to empty, then watch a few idle cycles for extras
  task automatic finish_test(input string name, input int base);
    int waited;
    waited = 0;
    idle(1);
    while (exp_tag_q.size() != 0 && waited < 64) begin
      @(negedge clk);
      waited++;
    end
    if (exp_tag_q.size() != 0) begin
      $display("Timeout in %0s: %0d results never came back", name, exp_tag_q.size());
      errors++;
      exp_sum_q.delete();
      exp_diff_q.delete();
      exp_tag_q.delete();
    end
    idle(4);
    report_test(name, base);
  endtask

  // --------------------------------------------------------------------------
  // Output monitor
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n && out_avail) begin
      assert (exp_tag_q.size() != 0) else begin
        $display("Result appeared at %0t with no item in flight", $time);
        errors++;
      end
      if (exp_tag_q.size() != 0) begin
        want_sum  = exp_sum_q.pop_front();
        want_diff = exp_diff_q.pop_front();
        want_tag  = exp_tag_q.pop_front();
        assert (sum == want_sum) else begin
          $display("ERR %0t: sum %h, expected %h", $time, sum, want_sum);
          errors++;
        end
        assert (diff == want_diff) else begin
          $display("ERR %0t: diff %h, expected %h", $time, diff, want_diff);
          errors++;
        end
        assert (out_tag == want_tag) else begin
          $display("ERR %0t: tag %h, expected %h", $time, out_tag, want_tag);
          errors++;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    rst_n    = 1'b0;
    a        = '0;
    b        = '0;
    in_avail = 1'b0;
    in_tag   = '0;
    errors   = 0;
    tests    = 0;
    seed     = 32'h4b4cf53e;

    // Reset held for 16 cycles, then a few idle cycles
    err_base = errors;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (i == 15) begin
        rst_n = 1'b1;
      end
      assert (out_avail == 1'b0) else begin
        $display("ERR %0t: out_avail high in reset or idle", $time);
        errors++;
      end
    end
    report_test("reset", err_base);

    // Small operands, latency counted in falling edges after the drive
    err_base = errors;
    send_known(66'd3, 66'd5, 8'h3c, 64'd8, GF64_P - 64'd2);
    lat = 0;
    do begin
      @(negedge clk);
      in_avail = 1'b0;
      lat++;
    end while (!out_avail && lat < 32);
    if (!out_avail) begin
      $display("Timeout: no result for the small operand item within 32 cycles");
      errors++;
    end else begin
      assert (lat == TOP_LAT) else begin
        $display("ERR %0t: latency %0d, expected %0d", $time, lat, TOP_LAT);
        errors++;
      end
    end
    finish_test("small", err_base);

    // Wrap, carry fold and sign fold extremes
    err_base = errors;
    send_known({2'b00, GF64_P - 64'd1}, 66'd1, 8'h11, 64'd0, GF64_P - 64'd2);
    send_item({2'b00, {64{1'b1}}}, {2'b00, {64{1'b1}}}, 8'h12);
    send_item({1'b0, {65{1'b1}}}, {1'b0, {65{1'b1}}}, 8'h13);
    send_item({1'b1, {65{1'b0}}}, {1'b1, {65{1'b0}}}, 8'h14);
    send_item({1'b0, {65{1'b1}}}, {1'b1, {65{1'b0}}}, 8'h15);
    send_item({1'b1, {65{1'b0}}}, {1'b0, {65{1'b1}}}, 8'h16);
    finish_test("edges", err_base);

    // Negative operands
    err_base = errors;
    send_known({OP_W{1'b1}}, 66'd0, 8'h21, GF64_P - 64'd1, GF64_P - 64'd1);
    send_known(66'd0, ~{2'b00, GF64_P - 64'd1} + 66'd1, 8'h22, 64'd1, GF64_P - 64'd1);
    finish_test("negative", err_base);

    // Back-to-back stream
    err_base = errors;
    for (int i = 0; i < 200; i++) begin
      ra = rand_operand();
      rb = rand_operand();
      rt = tag_t'($random(seed));
      send_item(ra, rb, rt);
    end
    finish_test("stream_b2b", err_base);

    // Stream with random idle gaps of 0 to 3 cycles
    err_base = errors;
    for (int i = 0; i < 200; i++) begin
      ra = rand_operand();
      rb = rand_operand();
      rt = tag_t'($random(seed));
      send_item(ra, rb, rt);
      gap = $unsigned($random(seed)) % 4;
      idle(gap);
    end
    finish_test("stream_gaps", err_base);

    total = errors + i_gf64_butterfly_top.u_checker.fail_count;
    $display("Summary: %0d tests, %0d errors (%0d from assertions)", tests, total,
             i_gf64_butterfly_top.u_checker.fail_count);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* test/gf64_butterfly_checker.sv */
// Concurrent checks on the butterfly top level, bound in from the testbench
// Assumes in_avail and in_tag are stable around the rising clock edge
// Data and tag are only compared while out_avail is high
module gf64_butterfly_checker (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       in_avail,
  input gf64_pkg::tag_t             in_tag,
  input logic                       out_avail,
  input gf64_pkg::tag_t             out_tag,
  input logic [gf64_pkg::MOD_W-1:0] sum,
  input logic [gf64_pkg::MOD_W-1:0] diff
);
  timeunit 1ns;
  timeprecision 1ps;
  import gf64_pkg::*;

  // Number of failed checks, added to the final error count
  int fail_count = 0;

  // --------------------------------------------------------------------------
  // Strobe timing
  // --------------------------------------------------------------------------

  // Every item comes out exactly TOP_LAT edges later, no loss, no repeat
  a_avail_lat : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_avail == $past(in_avail, TOP_LAT)
  ) else begin
    $error("out_avail does not follow in_avail by %0d cycles", TOP_LAT);
    fail_count++;
  end

  // Strobe chain held clear while in reset
  a_reset_idle : assert property (
    @(posedge clk)
    !rst_n |-> !out_avail
  ) else begin
    $error("out_avail high while rst_n is low");
    fail_count++;
  end

  // --------------------------------------------------------------------------
  // Result range and tag
  // --------------------------------------------------------------------------

  // Both residues canonical, below p
  a_residue_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_avail |-> ((sum < GF64_P) && (diff < GF64_P))
  ) else begin
    $error("residue out of range, sum %h diff %h", sum, diff);
    fail_count++;
  end

  // Tag rides along with its item
  a_tag_lat : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_avail |-> (out_tag == $past(in_tag, TOP_LAT))
  ) else begin
    $error("out_tag %h does not match the tag sent %0d cycles earlier", out_tag, TOP_LAT);
    fail_count++;
  end

endmodule

/* logic/gf64_butterfly_top.sv */
// Add/subtract half of a GF64 radix-2 butterfly, sum = a+b, diff = a-b mod p
// Both lanes have identical latency, so only the sum lane's strobe is used
// No back-pressure, outputs are valid for a single cycle
module gf64_butterfly_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [gf64_pkg::OP_W-1:0]  a,
  input  logic [gf64_pkg::OP_W-1:0]  b,
  input  logic                       in_avail,
  input  gf64_pkg::tag_t             in_tag,
  output logic [gf64_pkg::MOD_W-1:0] sum,
  output logic [gf64_pkg::MOD_W-1:0] diff,
  output logic                       out_avail,
  output gf64_pkg::tag_t             out_tag
);
  import gf64_pkg::*;

  // Sum lane partial result
  logic [PMR_W-1:0] add_z;
  logic             add_z_avail;
  tag_t             add_z_tag;

  // Difference lane partial result
  logic [PMR_W-1:0] sub_z;
  logic             sub_z_avail;

  // --------------------------------------------------------------------------
  // Sum lane
  // --------------------------------------------------------------------------
  gf64_pmr_addsub #(
    .SUB (1'b0)
  ) u_add_pmr (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (a),
    .b         (b),
    .in_avail  (in_avail),
    .in_tag    (in_tag),
    .z         (add_z),
    .out_avail (add_z_avail),
    .out_tag   (add_z_tag)
  );

  gf64_final_red u_add_red (
    .clk       (clk),
    .rst_n     (rst_n),
    .z         (add_z),
    .in_avail  (add_z_avail),
    .r         (sum),
    .out_avail (out_avail)
  );

  // Tag catch-up across the final stage
  gf64_delay_side #(
    .LATENCY (RED_LAT),
    .side_t  (tag_t)
  ) u_tag_dly (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_avail  (add_z_avail),
    .out_avail (),
    .in_side   (add_z_tag),
    .out_side  (out_tag)
  );

  // --------------------------------------------------------------------------
  // Difference lane
  // --------------------------------------------------------------------------
  // Strobe and tag copies stay open
  gf64_pmr_addsub #(
    .SUB (1'b1)
  ) u_sub_pmr (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (a),
    .b         (b),
    .in_avail  (in_avail),
    .in_tag    (in_tag),
    .z         (sub_z),
    .out_avail (sub_z_avail),
    .out_tag   ()
  );

  gf64_final_red u_sub_red (
    .clk       (clk),
    .rst_n     (rst_n),
    .z         (sub_z),
    .in_avail  (sub_z_avail),
    .r         (diff),
    .out_avail ()
  );

endmodule

/* logic/gf64_final_red.sv */
// Final reduction of a signed partial result to a canonical residue in [0, p)
// Input must lie in [-2p, 2p), which gf64_pmr_addsub guarantees
// Fixed latency of RED_LAT cycles, no stall
module gf64_final_red (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [gf64_pkg::PMR_W-1:0] z,
  input  logic                       in_avail,
  output logic [gf64_pkg::MOD_W-1:0] r,
  output logic                       out_avail
);
  import gf64_pkg::*;

  // p and 2p at the partial result width
  logic [PMR_W-1:0] p_ext;
  logic [PMR_W-1:0] p2_ext;

  assign p_ext  = {{(PMR_W-MOD_W){1'b0}}, GF64_P};
  assign p2_ext = {{(PMR_W-MOD_W-1){1'b0}}, GF64_P, 1'b0};

  // --------------------------------------------------------------------------
  // Stage one, lift negative values
  // --------------------------------------------------------------------------
  logic [PMR_W-1:0] z_plus_p;
  logic [PMR_W-1:0] z_plus_2p;
  logic [PMR_W-1:0] s0_pos;
  logic [PMR_W-1:0] s1_pos;

  // No overflow here since only negative z selects these sums
  assign z_plus_p  = z + p_ext;
  assign z_plus_2p = z + p2_ext;

  always_comb begin
    if (!z[PMR_W-1]) begin
      // Already non-negative, below 2p
      s0_pos = z;
    end else if (!z_plus_p[PMR_W-1]) begin
      // In [-p, 0)
      s0_pos = z_plus_p;
    end else begin
      // In [-2p, -p)
      s0_pos = z_plus_2p;
    end
  end

  always_ff @(posedge clk) begin
    s1_pos <= s0_pos;
  end

  // --------------------------------------------------------------------------
  // Stage two, strip whole multiples of p
  // --------------------------------------------------------------------------
  // s1_pos is in [0, 3p) so one compare pair is enough
  logic [PMR_W-1:0] s1_minus_p;
  logic [PMR_W-1:0] s1_minus_2p;
  logic [MOD_W-1:0] s1_r;
  logic [MOD_W-1:0] s2_r;

  assign s1_minus_p  = s1_pos - p_ext;
  assign s1_minus_2p = s1_pos - p2_ext;

  always_comb begin
    if (s1_pos >= p2_ext) begin
      s1_r = s1_minus_2p[MOD_W-1:0];
    end else if (s1_pos >= p_ext) begin
      s1_r = s1_minus_p[MOD_W-1:0];
    end else begin
      s1_r = s1_pos[MOD_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    s2_r <= s1_r;
  end

  assign r = s2_r;

  // --------------------------------------------------------------------------
  // Strobe alignment
  // --------------------------------------------------------------------------
  // No side payload on this stage, the tag travels outside
  gf64_delay_side #(
    .LATENCY (RED_LAT)
  ) u_side_dly (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_avail  (in_avail),
    .out_avail (out_avail),
    .in_side   (1'b0),
    .out_side  ()
  );

endmodule

/* logic/gf64_pmr_addsub.sv */
// Signed add (SUB=0) or subtract (SUB=1) with partial reduction mod p
// Inputs are 66-bit two's complement, result is 66-bit signed, not canonical
// Result range is roughly [-2^34, 2^64 + 3*2^32), well inside [-2p, 2p)
// Fixed latency of PMR_LAT cycles, no stall
module gf64_pmr_addsub #(
  parameter bit SUB = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [gf64_pkg::OP_W-1:0]  a,
  input  logic [gf64_pkg::OP_W-1:0]  b,
  input  logic                       in_avail,
  input  gf64_pkg::tag_t             in_tag,
  output logic [gf64_pkg::PMR_W-1:0] z,
  output logic                       out_avail,
  output gf64_pkg::tag_t             out_tag
);
  import gf64_pkg::*;

  // Fold relies on an even word
  generate
    if ((MOD_W % 2) != 0) begin : gen_bad_mod_w
      $fatal(1, "gf64_pmr_addsub: MOD_W (%0d) must be even", MOD_W);
    end
  endgenerate

  // --------------------------------------------------------------------------
  // Input register
  // --------------------------------------------------------------------------
  logic [OP_W-1:0] s0_a;
  logic [OP_W-1:0] s0_b;

  always_ff @(posedge clk) begin
    s0_a <= a;
    s0_b <= b;
  end

  // --------------------------------------------------------------------------
  // Add or subtract, one bit wider so nothing overflows
  // --------------------------------------------------------------------------
  logic [OP_W:0] s0_a_ext;
  logic [OP_W:0] s0_b_ext;
  logic [OP_W:0] s0_res;
  logic [OP_W:0] s1_res;

  // Sign extend by one bit
  assign s0_a_ext = {s0_a[OP_W-1], s0_a};
  assign s0_b_ext = {s0_b[OP_W-1], s0_b};
  assign s0_res   = SUB ? (s0_a_ext - s0_b_ext) : (s0_a_ext + s0_b_ext);

  always_ff @(posedge clk) begin
    s1_res <= s0_res;
  end

  // --------------------------------------------------------------------------
  // Partial fold with 2^64 = 2^32 - 1 mod p
  // --------------------------------------------------------------------------
  // s1_res = low + carry * 2^64 - sign * 2^66
  // carry term becomes carry * (2^32 - 1)
  // sign term becomes 4 * (2^32 - 1)
  logic                    s1_sign;
  logic [OP_W-MOD_W-1:0]   s1_carry;
  logic [PMR_W-1:0]        s1_low;
  logic [PMR_W-1:0]        s1_carry_fold;
  logic [PMR_W-1:0]        s1_sign_fold;
  logic [PMR_W-1:0]        s1_z;

  assign s1_sign  = s1_res[OP_W];
  assign s1_carry = s1_res[OP_W-1:MOD_W];

  // Low word, zero extended to the result width
  assign s1_low = {{(PMR_W-MOD_W){1'b0}}, s1_res[MOD_W-1:0]};

  // carry * 2^32 - carry
  assign s1_carry_fold = {{(PMR_W-MID_W-(OP_W-MOD_W)){1'b0}}, s1_carry, {MID_W{1'b0}}}
                       - {{(PMR_W-(OP_W-MOD_W)){1'b0}}, s1_carry};

  // (2^32 - 1) shifted up by the carry width
  assign s1_sign_fold = {{(PMR_W-MID_W-(OP_W-MOD_W)){1'b0}},
                         {MID_W{s1_sign}},
                         {(OP_W-MOD_W){1'b0}}};

  // Two's complement wrap gives the signed result directly
  assign s1_z = s1_low + s1_carry_fold - s1_sign_fold;

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  logic [PMR_W-1:0] s2_z;

  always_ff @(posedge clk) begin
    s2_z <= s1_z;
  end

  assign z = s2_z;

  // Strobe and tag follow the three data registers
  gf64_delay_side #(
    .LATENCY (PMR_LAT),
    .side_t  (tag_t)
  ) u_side_dly (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_avail  (in_avail),
    .out_avail (out_avail),
    .in_side   (in_tag),
    .out_side  (out_tag)
  );

endmodule

/* logic/gf64_delay_side.sv */
// Fixed delay line for an avail strobe and a typed side payload
// Only the strobe chain is reset, the payload chain powers up unknown
// LATENCY must be at least 1
module gf64_delay_side #(
  parameter int  LATENCY = 1,
  parameter type side_t  = logic
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_avail,
  output logic  out_avail,
  input  side_t in_side,
  output side_t out_side
);

  // Zero or negative depth makes no sense here
  generate
    if (LATENCY < 1) begin : gen_bad_latency
      $fatal(1, "gf64_delay_side: LATENCY (%0d) must be at least 1", LATENCY);
    end
  endgenerate

  // --------------------------------------------------------------------------
  // Strobe chain
  // --------------------------------------------------------------------------
  logic avail_q [LATENCY];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LATENCY; i++) begin
        avail_q[i] <= 1'b0;
      end
    end else begin
      avail_q[0] <= in_avail;
      for (int i = 1; i < LATENCY; i++) begin
        avail_q[i] <= avail_q[i-1];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Payload chain
  // --------------------------------------------------------------------------
  side_t side_q [LATENCY];

  // Plain shift, qualified downstream by the strobe
  always_ff @(posedge clk) begin
    side_q[0] <= in_side;
    for (int i = 1; i < LATENCY; i++) begin
      side_q[i] <= side_q[i-1];
    end
  end

  assign out_avail = avail_q[LATENCY-1];
  assign out_side  = side_q[LATENCY-1];

endmodule

/* logic/gf64_pkg.sv */
// Shared constants and types for the GF64 add/subtract butterfly
// Field word fixed at 64 bits with prime p = 2^64 - 2^32 + 1
// Operands and partial results are two's complement
package gf64_pkg;

  // --------------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------------

  // Field word width, must stay even for the 2^32 fold
  localparam int MOD_W = 64;

  // Operand width with one extra magnitude bit and a sign bit
  localparam int OP_W = MOD_W + 2;

  // Partial reduction result, signed
  localparam int PMR_W = MOD_W + 2;

  // Fold position, 2^64 = 2^32 - 1 mod p
  localparam int MID_W = MOD_W / 2;

  // Goldilocks prime
  localparam logic [MOD_W-1:0] GF64_P = 64'hFFFF_FFFF_0000_0001;

  // --------------------------------------------------------------------------
  // Side data
  // --------------------------------------------------------------------------

  // User tag carried beside each item
  typedef logic [7:0] tag_t;

  // --------------------------------------------------------------------------
  // Stage latencies in clock cycles
  // --------------------------------------------------------------------------

  // Input reg, sum reg, output reg
  localparam int PMR_LAT = 3;
  // Offset reg, output reg
  localparam int RED_LAT = 2;
  // Whole lane
  localparam int TOP_LAT = PMR_LAT + RED_LAT;

endpackage
